//--- Makefile
# Verilator build and run of the crossbar testbench

TOP = tb_tdma_crossbar
LOG = sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list these targets"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove the build folder and the log"

test:
	verilator --binary --timing --assert --top-module $(TOP) \
		-f tdma_crossbar.f -o sim_$(TOP)
	./obj_dir/sim_$(TOP) | tee $(LOG)
	@if grep -q "RESULT: FAIL" $(LOG); then echo "simulation failed"; exit 1; fi
	@if ! grep -q "RESULT: PASS" $(LOG); then echo "simulation did not finish"; exit 1; fi

clean:
	rm -rf obj_dir $(LOG)

//--- broadcast_router.sv
// broadcast router, registers the popped word into every output lane
// together with the source id and a one-cycle valid
`timescale 1ns/1ps

module broadcast_router (
    input logic clk,
    input logic rst_n,
    slot_if.router rtr,
    output logic out_valid,
    output tdma_pkg::port_id_t out_src,
    output tdma_pkg::data_t out_data [tdma_pkg::NUM_PORTS]
);
    import tdma_pkg::*;

    // valid and source id stage
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            out_valid <= 1'b0;
            out_src <= '0;
        end else begin
            out_valid <= rtr.pop_valid;
            // slot owner is the granted port
            if (rtr.pop_valid) begin
                out_src <= rtr.slot_idx;
            end
        end
    end

    // one register per lane keeps the fan-out local
    genvar i;
    generate
        for (i = 0; i < NUM_PORTS; i++) begin : g_lane
            always_ff @(posedge clk or negedge rst_n) begin
                if (!rst_n) begin
                    out_data[i] <= '0;
                end else if (rtr.pop_valid) begin
                    out_data[i] <= rtr.pop_data;
                end
            end
        end
    endgenerate

endmodule

//--- ingress_port.sv
// ingress port, one-word buffer behind a four-phase req/ack handshake
`timescale 1ns/1ps

module ingress_port (
    input logic clk,
    input logic rst_n,
    input logic req,
    input tdma_pkg::data_t data,
    output logic ack,
    input logic grant_me,
    output logic full,
    output tdma_pkg::data_t word
);

    // handshake states held in ack and full
    //   empty wait : !ack && !full
    //   acked      :  ack, waiting for req to drop
    //   released   : !ack &&  full, word waits for its slot
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ack <= 1'b0;
            full <= 1'b0;
        end else begin
            // scheduler took the word
            if (grant_me) begin
                full <= 1'b0;
            end
            if (ack) begin
                if (!req) begin
                    ack <= 1'b0;
                end
            end else if (req && !full) begin
                full <= 1'b1;
                ack <= 1'b1;
            end
        end
    end

    // payload only, written on capture
    always_ff @(posedge clk) begin
        if (!ack && req && !full) begin
            word <= data;
        end
    end

    a_grant_needs_word: assert property (
        @(posedge clk) disable iff (!rst_n)
        grant_me |-> full
    );

    // source must wait for ack low before a new request
    a_release: assert property (
        @(posedge clk) disable iff (!rst_n)
        $rose(req) |-> !ack
    );

endmodule

//--- slot_if.sv
// slot timing, grant and pop path shared by timer, scheduler,
// ingress ports and router
`timescale 1ns/1ps

interface slot_if;
    import tdma_pkg::*;

    logic slot_start;
    port_id_t slot_idx;
    logic [NUM_PORTS-1:0] grant;
    logic [NUM_PORTS-1:0] full;
    data_t pop_data;
    logic pop_valid;

    modport timer (
        output slot_start,
        output slot_idx
    );

    modport sched (
        output grant,
        output pop_valid,
        input slot_start,
        input slot_idx,
        input full
    );

    modport port (
        output full,
        output pop_data,
        input grant
    );

    modport router (
        input pop_valid,
        input pop_data,
        input slot_idx
    );

endinterface

//--- slot_timer.sv
// slot timer, counts clocks per slot and steps the slot index
// round robin over the ports
`timescale 1ns/1ps

module slot_timer (
    input logic clk,
    input logic rst_n,
    slot_if.timer tim
);
    import tdma_pkg::*;

    logic [CNT_W-1:0] cnt;
    port_id_t slot_idx;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cnt <= '0;
            slot_idx <= '0;
        end else if (cnt == SLOT_LAST) begin
            cnt <= '0;
            // next slot belongs to the next port
            if (slot_idx == PORT_LAST) begin
                slot_idx <= '0;
            end else begin
                slot_idx <= slot_idx + 1'b1;
            end
        end else begin
            cnt <= cnt + 1'b1;
        end
    end

    // count 0 opens the slot, slot_idx is already the new owner here
    assign tim.slot_start = (cnt == '0);
    assign tim.slot_idx = slot_idx;

    // the count wraps back to zero after one full slot
    a_slot_period: assert property (
        @(posedge clk) disable iff (!rst_n)
        tim.slot_start |-> ##SLOT_CYCLES tim.slot_start
    );

    // owner only changes at a slot boundary
    a_idx_at_start: assert property (
        @(posedge clk) disable iff (!rst_n)
        (tim.slot_idx != $past(tim.slot_idx)) |-> tim.slot_start
    );

endmodule

//--- tb_tdma_crossbar.sv
// testbench for the time-division crossbar, random four-phase sources,
// per-port reference queues, compare tasks and a watchdog
`timescale 1ns/1ps

module tb_tdma_crossbar;
    import tdma_pkg::*;

    localparam int TESTS = 4;
    localparam int WORDS = 12;
    localparam int MAX_GAP = 40;
    localparam int LIMIT = TESTS * NUM_PORTS * SLOT_CYCLES * WORDS * 2;

    logic clk;
    logic rst_n;
    logic [NUM_PORTS-1:0] in_req;
    data_t in_data [NUM_PORTS];
    logic [NUM_PORTS-1:0] in_ack;
    logic out_valid;
    port_id_t out_src;
    data_t out_data [NUM_PORTS];

    // words acknowledged but not yet seen at the output
    data_t exp_q [NUM_PORTS][$];

    int errors = 0;
    int tests_run = 0;
    int tests_failed = 0;
    int words_out = 0;
    bit rr_check = 1'b0;
    bit have_last = 1'b0;

    tdma_crossbar dut (
        .clk(clk),
        .rst_n(rst_n),
        .in_req(in_req),
        .in_data(in_data),
        .in_ack(in_ack),
        .out_valid(out_valid),
        .out_src(out_src),
        .out_data(out_data)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    task automatic check_data(input data_t expected, input data_t actual, input string name);
        if (actual !== expected) begin
            errors++;
            $display("Error: %s expected 0x%h got 0x%h", name, expected, actual);
        end
    endtask

    task automatic check_src(input port_id_t expected, input port_id_t actual);
        if (actual !== expected) begin
            errors++;
            $display("Error: out_src expected 0x%h got 0x%h", expected, actual);
        end
    endtask

    task automatic check_bit(input logic expected, input logic actual, input string name);
        if (actual !== expected) begin
            errors++;
            $display("Error: %s expected 0x%h got 0x%h", name, expected, actual);
        end
    endtask

    function automatic int pending_words();
        int n;
        n = 0;
        for (int p = 0; p < NUM_PORTS; p++) begin
            n += exp_q[p].size();
        end
        return n;
    endfunction

    // four-phase req/ack for count words, random idle gap before each
    task automatic run_source(input int p, input int count, input int max_gap);
        int gap;
        for (int n = 0; n < count; n++) begin
            gap = (max_gap == 0) ? 0 : int'($urandom_range(max_gap, 0));
            repeat (gap) @(posedge clk);
            in_data[p] <= data_t'($urandom);
            in_req[p] <= 1'b1;
            @(posedge clk);
            while (!in_ack[p]) @(posedge clk);
            in_req[p] <= 1'b0;
            @(posedge clk);
            while (in_ack[p]) @(posedge clk);
        end
    endtask

    task automatic wait_drain();
        int waited;
        waited = 0;
        // a held word leaves within one round of slots
        while (pending_words() != 0 && waited < 2 * NUM_PORTS * SLOT_CYCLES) begin
            @(posedge clk);
            waited++;
        end
        if (pending_words() != 0) begin
            errors++;
            $display("%0d words were acknowledged but never output", pending_words());
        end
        repeat (4) @(posedge clk);
    endtask

    task automatic finish_test(input string name, input int err_before);
        tests_run++;
        if (errors == err_before) begin
            $display("test %-12s ok", name);
        end else begin
            tests_failed++;
            $display("test %-12s failed with %0d errors", name, errors - err_before);
        end
    endtask

    // output side of the reference model
    initial begin
        int cycle;
        int last_cycle;
        port_id_t last_src;
        logic [NUM_PORTS-1:0] ack_prev;
        data_t exp_word;
        cycle = 0;
        last_cycle = -1000;
        last_src = '0;
        ack_prev = '0;
        forever begin
            @(posedge clk);
            if (rst_n) begin
                if (out_valid) begin
                    words_out++;
                    if (exp_q[out_src].size() == 0) begin
                        errors++;
                        $display("output seen from port %0d while it had no pending word",
                            out_src);
                    end else begin
                        exp_word = exp_q[out_src].pop_front();
                        // every lane carries the same word
                        for (int i = 0; i < NUM_PORTS; i++) begin
                            check_data(exp_word, out_data[i], $sformatf("out_data[%0d]", i));
                        end
                    end
                    if (cycle - last_cycle < SLOT_CYCLES) begin
                        errors++;
                        $display("two outputs only %0d cycles apart", cycle - last_cycle);
                    end
                    if (rr_check && have_last) begin
                        check_src(port_id_t'(last_src + 1), out_src);
                    end
                    last_src = out_src;
                    have_last = 1'b1;
                    last_cycle = cycle;
                end
                // rising ack means the port captured the word on in_data
                for (int p = 0; p < NUM_PORTS; p++) begin
                    if (in_ack[p] && !ack_prev[p]) begin
                        if (exp_q[p].size() != 0) begin
                            errors++;
                            $display("port %0d acknowledged a word while one was pending", p);
                        end
                        exp_q[p].push_back(in_data[p]);
                    end
                end
                ack_prev = in_ack;
                cycle++;
            end
        end
    end

    initial begin
        repeat (LIMIT) @(posedge clk);
        $display("timeout after %0d cycles, %0d words still pending", LIMIT, pending_words());
        $display("RESULT: FAIL");
        $finish;
    end

    initial begin
        int err_mark;
        void'($urandom(32'haa4a_9d82));
        rst_n = 1'b0;
        in_req = '0;
        for (int i = 0; i < NUM_PORTS; i++) begin
            in_data[i] = '0;
        end

        // reset values, sampled while reset is still held
        repeat (5) @(posedge clk);
        err_mark = errors;
        check_bit(1'b0, out_valid, "out_valid");
        for (int i = 0; i < NUM_PORTS; i++) begin
            check_bit(1'b0, in_ack[i], $sformatf("in_ack[%0d]", i));
            check_data('0, out_data[i], $sformatf("out_data[%0d]", i));
        end
        rst_n <= 1'b1;
        finish_test("reset", err_mark);

        @(posedge clk);
        err_mark = errors;
        fork
            run_source(0, WORDS, MAX_GAP);
            run_source(1, WORDS, MAX_GAP);
            run_source(2, WORDS, MAX_GAP);
            run_source(3, WORDS, MAX_GAP);
        join
        wait_drain();
        finish_test("random", err_mark);

        // all ports busy, every slot carries a word
        @(posedge clk);
        err_mark = errors;
        have_last = 1'b0;
        rr_check = 1'b1;
        fork
            run_source(0, WORDS, 0);
            run_source(1, WORDS, 0);
            run_source(2, WORDS, 0);
            run_source(3, WORDS, 0);
        join
        wait_drain();
        rr_check = 1'b0;
        finish_test("full_load", err_mark);

        // one source back to back, ack held off while its word waits
        @(posedge clk);
        err_mark = errors;
        run_source(2, WORDS, 0);
        wait_drain();
        finish_test("single_port", err_mark);

        $display("tests %0d, failed %0d, words %0d, errors %0d",
            tests_run, tests_failed, words_out, errors);
        if (errors == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

//--- tdma_crossbar.f
tdma_pkg.sv
slot_if.sv
slot_timer.sv
tdma_scheduler.sv
ingress_port.sv
broadcast_router.sv
tdma_crossbar.sv
tb_tdma_crossbar.sv

//--- tdma_crossbar.sv
// crossbar top, slot timer, scheduler, four ingress ports and the
// broadcast router around one slot interface
`timescale 1ns/1ps

module tdma_crossbar (
    input logic clk,
    input logic rst_n,
    input logic [tdma_pkg::NUM_PORTS-1:0] in_req,
    input tdma_pkg::data_t in_data [tdma_pkg::NUM_PORTS],
    output logic [tdma_pkg::NUM_PORTS-1:0] in_ack,
    output logic out_valid,
    output tdma_pkg::port_id_t out_src,
    output tdma_pkg::data_t out_data [tdma_pkg::NUM_PORTS]
);
    import tdma_pkg::*;

    slot_if sif ();

    logic [NUM_PORTS-1:0] port_full;
    data_t port_word [NUM_PORTS];

    slot_timer u_timer (
        .clk(clk),
        .rst_n(rst_n),
        .tim(sif.timer)
    );

    tdma_scheduler u_sched (
        .clk(clk),
        .rst_n(rst_n),
        .sch(sif.sched)
    );

    genvar g;
    generate
        for (g = 0; g < NUM_PORTS; g++) begin : g_port
            ingress_port u_port (
                .clk(clk),
                .rst_n(rst_n),
                .req(in_req[g]),
                .data(in_data[g]),
                .ack(in_ack[g]),
                .grant_me(sif.grant[g]),
                .full(port_full[g]),
                .word(port_word[g])
            );
        end
    endgenerate

    assign sif.full = port_full;

    // one-hot select of the granted buffer
    always_comb begin
        sif.pop_data = '0;
        for (int i = 0; i < NUM_PORTS; i++) begin
            if (sif.grant[i]) begin
                sif.pop_data = sif.pop_data | port_word[i];
            end
        end
    end

    broadcast_router u_router (
        .clk(clk),
        .rst_n(rst_n),
        .rtr(sif.router),
        .out_valid(out_valid),
        .out_src(out_src),
        .out_data(out_data)
    );

endmodule

//--- tdma_pkg.sv
// sizes, word and index types, slot constants and scheduler states
// for the four-port time-division crossbar

package tdma_pkg;

    // port count and word width
    localparam int NUM_PORTS = 4;
    localparam int DATA_W = 8;

    // slot length in clocks
    localparam int SLOT_CYCLES = 16;

    // index and counter widths
    localparam int PORT_W = 2;
    localparam int CNT_W = 4;

    // last count of a slot and last slot of a round
    localparam logic [CNT_W-1:0] SLOT_LAST = CNT_W'(SLOT_CYCLES - 1);
    localparam logic [PORT_W-1:0] PORT_LAST = PORT_W'(NUM_PORTS - 1);

    typedef logic [DATA_W-1:0] data_t;

    typedef logic [PORT_W-1:0] port_id_t;

    // scheduler FSM, one pass per slot
    typedef enum logic [1:0] {
        S_IDLE,
        S_WAIT_SLOT,
        S_GRANT,
        S_FORWARD
    } sched_state_t;

endpackage

//--- tdma_scheduler.sv
// scheduler FSM, opens each slot, grants the owning port when it
// holds a word and raises pop_valid for the router
`timescale 1ns/1ps

module tdma_scheduler (
    input logic clk,
    input logic rst_n,
    slot_if.sched sch
);
    import tdma_pkg::*;

    sched_state_t state;
    logic [NUM_PORTS-1:0] owner_hot;

    // one-hot of the current slot owner
    always_comb begin
        owner_hot = '0;
        owner_hot[sch.slot_idx] = 1'b1;
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= S_IDLE;
            sch.grant <= '0;
            sch.pop_valid <= 1'b0;
        end else begin
            // grant is a single cycle pulse
            sch.grant <= '0;
            sch.pop_valid <= 1'b0;
            case (state)
                S_IDLE: begin
                    state <= S_WAIT_SLOT;
                end
                S_WAIT_SLOT: begin
                    if (sch.slot_start) begin
                        state <= S_GRANT;
                        // empty owner leaves the slot idle
                        if (sch.full[sch.slot_idx]) begin
                            sch.grant <= owner_hot;
                            sch.pop_valid <= 1'b1;
                        end
                    end
                end
                S_GRANT: begin
                    // port drops full, router loads the word
                    state <= S_FORWARD;
                end
                S_FORWARD: begin
                    // router output valid this cycle
                    state <= S_WAIT_SLOT;
                end
                default: begin
                    state <= S_IDLE;
                end
            endcase
        end
    end

    a_grant_onehot: assert property (
        @(posedge clk) disable iff (!rst_n)
        $onehot0(sch.grant)
    );

    a_pop_matches_grant: assert property (
        @(posedge clk) disable iff (!rst_n)
        sch.pop_valid == (sch.grant != '0)
    );

endmodule
